// ==== invaders_pkg.sv ====
// Shared game types, play-field constants and the debouncer state encoding
// for the player side of the invaders game.
package invaders_pkg;

	// Play field.
	localparam int NUM_COLS = 20;

	typedef logic [4:0] col_t; // Column index, 0 to NUM_COLS-1.
	typedef logic [3:0] row_t; // Missile row, 0 is the invader row.
	typedef logic [7:0] score_t;
	typedef logic [NUM_COLS-1:0] alive_t; // Bit i is the invader above column i.

	localparam col_t SHIP_HOME = 5'd5;

	// Missile.
	localparam row_t MISSILE_START_ROW = 4'd14;
	localparam int STEP_CYCLES = 8; // Clocks per row step.

	// Buttons.
	localparam int DEBOUNCE_CYCLES = 4; // Equal samples to accept a level.

	// Debouncer: two stable levels, each with a confirming state in front.
	typedef enum logic [1:0] {
		idle_low,
		wait_high,
		held_high,
		wait_low
	} deb_state_t;

endpackage

// ==== button_debounce.sv ====
// Debouncer for one raw push button, producing a single-cycle press pulse
// once per stable press.
`timescale 1ns/1ps

module button_debounce (
	input  logic clk,
	input  logic reset,
	input  logic btn,
	output logic press
);

	invaders_pkg::deb_state_t state;
	logic [$clog2(invaders_pkg::DEBOUNCE_CYCLES)-1:0] cnt; // Equal samples so far, minus one.
	logic confirmed;

	// Last sample of a full run of equal levels.
	assign confirmed = (cnt == ($bits(cnt))'(invaders_pkg::DEBOUNCE_CYCLES - 1));

	always_ff @(posedge clk) begin
		if (!reset) begin
			state <= invaders_pkg::idle_low;
			cnt   <= '0;
			press <= 1'b0;
		end else begin
			press <= 1'b0;
			case (state)
				invaders_pkg::idle_low: begin
					if (btn) begin
						state <= invaders_pkg::wait_high;
						cnt   <= ($bits(cnt))'(1);
					end
				end
				invaders_pkg::wait_high: begin
					if (!btn) begin
						state <= invaders_pkg::idle_low; // Bounce, start over.
					end else if (confirmed) begin
						state <= invaders_pkg::held_high;
						press <= 1'b1;
					end else begin
						cnt <= cnt + 1'b1;
					end
				end
				invaders_pkg::held_high: begin
					if (!btn) begin
						state <= invaders_pkg::wait_low;
						cnt   <= ($bits(cnt))'(1);
					end
				end
				invaders_pkg::wait_low: begin
					// Release bounce falls back to held, so no second press.
					if (btn) begin
						state <= invaders_pkg::held_high;
					end else if (confirmed) begin
						state <= invaders_pkg::idle_low;
					end else begin
						cnt <= cnt + 1'b1;
					end
				end
				default: state <= invaders_pkg::idle_low;
			endcase
		end
	end

endmodule

// ==== ship_position.sv ====
// Ship column register, stepped by left and right press pulses and held
// inside the play field.
`timescale 1ns/1ps

module ship_position (
	input  logic                clk,
	input  logic                reset,
	input  logic                enable,
	input  logic                left_press,
	input  logic                right_press,
	output invaders_pkg::col_t  ship_x
);

	logic at_left;
	logic at_right;

	assign at_left  = (ship_x == '0);
	assign at_right = (ship_x == invaders_pkg::col_t'(invaders_pkg::NUM_COLS - 1));

	always_ff @(posedge clk) begin
		if (!reset) begin
			ship_x <= invaders_pkg::SHIP_HOME;
		end else if (enable) begin
			// Left has priority when both buttons fire together.
			if (left_press) begin
				if (!at_left) begin
					ship_x <= ship_x - 1'b1;
				end
			end else if (right_press) begin
				if (!at_right) begin
					ship_x <= ship_x + 1'b1;
				end
			end
		end
	end

	ship_in_field: assert property (
		@(posedge clk) disable iff (!reset)
		ship_x < invaders_pkg::NUM_COLS
	) else $error("ship column %0d outside play field", ship_x);

endmodule

// ==== missile_unit.sv ====
// Single player missile: launch from the ship column, timed climb toward
// the invader row and an arrival pulse when it gets there.
`timescale 1ns/1ps

module missile_unit (
	input  logic                clk,
	input  logic                reset,
	input  logic                enable,
	input  logic                fire_press,
	input  invaders_pkg::col_t  ship_x,
	output logic                missile_active,
	output invaders_pkg::row_t  missile_row,
	output invaders_pkg::col_t  missile_col,
	output logic                missile_arrive
);

	logic [$clog2(invaders_pkg::STEP_CYCLES)-1:0] step_timer;
	logic launch;
	logic step;

	assign launch = fire_press && enable && !missile_active;
	assign step   = missile_active && enable &&
	                (step_timer == ($bits(step_timer))'(invaders_pkg::STEP_CYCLES - 1));

	// Control state.
	always_ff @(posedge clk) begin
		if (!reset) begin
			missile_active <= 1'b0;
			missile_arrive <= 1'b0;
			step_timer     <= '0;
		end else begin
			missile_arrive <= 1'b0;
			if (launch) begin
				missile_active <= 1'b1;
				step_timer     <= '0;
			end else if (missile_active && enable) begin
				step_timer <= step_timer + 1'b1; // Wraps at STEP_CYCLES.
				if (step && missile_row == '0) begin
					missile_active <= 1'b0;
					missile_arrive <= 1'b1;
				end
			end
		end
	end

	// Position of the missile in flight.
	always_ff @(posedge clk) begin
		if (launch) begin
			missile_row <= invaders_pkg::MISSILE_START_ROW;
			missile_col <= ship_x; // Column stays fixed for the whole flight.
		end else if (step && missile_row != '0) begin
			missile_row <= missile_row - 1'b1;
		end
	end

	row_in_range: assert property (
		@(posedge clk) disable iff (!reset)
		missile_active |-> (missile_row <= invaders_pkg::MISSILE_START_ROW)
	) else $error("missile row %0d above start row", missile_row);

endmodule

// ==== hit_tracker.sv ====
// Invader alive mask and score, updated from missile arrivals, plus the
// wave-clear flag.
`timescale 1ns/1ps

module hit_tracker (
	input  logic                  clk,
	input  logic                  reset,
	input  logic                  missile_arrive,
	input  invaders_pkg::col_t    missile_col,
	output invaders_pkg::alive_t  invaders_alive,
	output invaders_pkg::score_t  score,
	output logic                  wave_clear
);

	logic hit;

	// Arrival over a dead invader is a miss.
	assign hit = missile_arrive && invaders_alive[missile_col];

	always_ff @(posedge clk) begin
		if (!reset) begin
			invaders_alive <= '1;
			score          <= '0;
		end else if (hit) begin
			invaders_alive[missile_col] <= 1'b0;
			score                       <= score + invaders_pkg::score_t'(1);
		end
	end

	assign wave_clear = (invaders_alive == '0);

	// Score moves only as the result of a missile arrival one clock earlier.
	score_from_arrival: assert property (
		@(posedge clk) disable iff (!reset)
		$changed(score) |-> $past(missile_arrive)
	) else $error("score changed without a missile arrival");

endmodule

// ==== invaders_core.sv ====
// Player-side top level: button debouncers, ship, missile and hit tracking.
`timescale 1ns/1ps

module invaders_core (
	input  logic                  clk,
	input  logic                  reset,
	input  logic                  enable,
	input  logic                  btn_left,
	input  logic                  btn_right,
	input  logic                  btn_fire,
	output invaders_pkg::col_t    ship_x,
	output logic                  missile_active,
	output invaders_pkg::row_t    missile_row,
	output invaders_pkg::col_t    missile_col,
	output invaders_pkg::alive_t  invaders_alive,
	output invaders_pkg::score_t  score,
	output logic                  wave_clear
);

	logic left_press;
	logic right_press;
	logic fire_press;
	logic missile_arrive;

	button_debounce u_deb_left (
		.clk   (clk),
		.reset (reset),
		.btn   (btn_left),
		.press (left_press)
	);

	button_debounce u_deb_right (
		.clk   (clk),
		.reset (reset),
		.btn   (btn_right),
		.press (right_press)
	);

	button_debounce u_deb_fire (
		.clk   (clk),
		.reset (reset),
		.btn   (btn_fire),
		.press (fire_press)
	);

	ship_position u_ship (
		.clk         (clk),
		.reset       (reset),
		.enable      (enable),
		.left_press  (left_press),
		.right_press (right_press),
		.ship_x      (ship_x)
	);

	missile_unit u_missile (
		.clk            (clk),
		.reset          (reset),
		.enable         (enable),
		.fire_press     (fire_press),
		.ship_x         (ship_x),
		.missile_active (missile_active),
		.missile_row    (missile_row),
		.missile_col    (missile_col),
		.missile_arrive (missile_arrive)
	);

	hit_tracker u_hits (
		.clk            (clk),
		.reset          (reset),
		.missile_arrive (missile_arrive),
		.missile_col    (missile_col),
		.invaders_alive (invaders_alive),
		.score          (score),
		.wave_clear     (wave_clear)
	);

endmodule

// ==== tb_invaders_core.sv ====
// Directed testbench for the invaders player core, with a reference model
// of the ship column, the invader alive mask and the score.
`timescale 1ns/1ps

module tb_invaders_core;

	logic                  clk;
	logic                  reset;
	logic                  enable;
	logic                  btn_left;
	logic                  btn_right;
	logic                  btn_fire;
	invaders_pkg::col_t    ship_x;
	logic                  missile_active;
	invaders_pkg::row_t    missile_row;
	invaders_pkg::col_t    missile_col;
	invaders_pkg::alive_t  invaders_alive;
	invaders_pkg::score_t  score;
	logic                  wave_clear;

	// Reference model state.
	int                    exp_ship;
	invaders_pkg::alive_t  exp_alive;
	int                    exp_score;
	logic                  exp_flying; // Model missile in flight.
	int                    exp_col;

	int                    errors;
	int                    checks;
	int unsigned           rand_val;

	invaders_core u_invaders_core (
		.clk            (clk),
		.reset          (reset),
		.enable         (enable),
		.btn_left       (btn_left),
		.btn_right      (btn_right),
		.btn_fire       (btn_fire),
		.ship_x         (ship_x),
		.missile_active (missile_active),
		.missile_row    (missile_row),
		.missile_col    (missile_col),
		.invaders_alive (invaders_alive),
		.score          (score),
		.wave_clear     (wave_clear)
	);

	initial begin
		clk = 1'b0;
		forever #5 clk = ~clk;
	end

	task automatic check_equal(input string name, input logic [31:0] actual,
		input logic [31:0] expected);
		checks++;
		if (actual !== expected) begin
			errors++;
			$display("ERROR at %0t: %s is 0x%0h, expected 0x%0h", $time, name, actual, expected);
		end
	endtask

	task automatic finish_run();
		$display("Checks: %0d, errors: %0d", checks, errors);
		if (errors == 0) begin
			$display("TESTBENCH PASSED");
		end else begin
			$display("TESTBENCH FAILED");
		end
		$finish;
	endtask

	// Compare every observable output with the model.
	task automatic check_state();
		check_equal("ship_x", 32'(ship_x), 32'(exp_ship));
		check_equal("invaders_alive", 32'(invaders_alive), 32'(exp_alive));
		check_equal("score", 32'(score), 32'(exp_score));
		check_equal("wave_clear", 32'(wave_clear), 32'(exp_alive == '0));
		check_equal("missile_active", 32'(missile_active), 32'(exp_flying));
		if (exp_flying) begin
			check_equal("missile_col", 32'(missile_col), 32'(exp_col));
		end
	endtask

	// Hold the chosen buttons, release them, then update the model.
	task automatic press_buttons(input logic left, input logic right, input logic fire,
		input int hold);
		@(negedge clk);
		btn_left  = left;
		btn_right = right;
		btn_fire  = fire;
		repeat (hold) @(negedge clk);
		btn_left  = 1'b0;
		btn_right = 1'b0;
		btn_fire  = 1'b0;
		repeat (invaders_pkg::DEBOUNCE_CYCLES + 2) @(negedge clk);
		if (hold >= invaders_pkg::DEBOUNCE_CYCLES && enable) begin
			if (fire && !exp_flying) begin
				exp_flying = 1'b1;
				exp_col    = exp_ship; // Column before any move in the same cycle.
			end
			if (left) begin
				if (exp_ship > 0) begin
					exp_ship--;
				end
			end else if (right) begin
				if (exp_ship < invaders_pkg::NUM_COLS - 1) begin
					exp_ship++;
				end
			end
		end
	endtask

	task automatic tap(input logic left, input logic right, input logic fire);
		press_buttons(left, right, fire, invaders_pkg::DEBOUNCE_CYCLES + 1);
	endtask

	task automatic wait_missile_done();
		int cycles;
		cycles = 0;
		while (missile_active && cycles < 400) begin
			@(negedge clk);
			cycles++;
		end
		if (missile_active) begin
			errors++;
			$display("Timeout: missile still in flight after %0d cycles", cycles);
			finish_run();
		end else begin
			@(negedge clk); // Hit tracker updates one clock after arrival.
			if (exp_flying) begin
				if (exp_alive[exp_col]) begin
					exp_alive[exp_col] = 1'b0;
					exp_score++;
				end
				exp_flying = 1'b0;
			end
		end
	endtask

	task automatic reset_values();
		check_equal("ship_x", 32'(ship_x), 32'(invaders_pkg::SHIP_HOME));
		check_equal("missile_active", 32'(missile_active), 32'd0);
		check_equal("invaders_alive", 32'(invaders_alive), 32'hfffff);
		check_equal("score", 32'(score), 32'd0);
		check_equal("wave_clear", 32'(wave_clear), 32'd0);
	endtask

	task automatic debounce_filter();
		int hold;
		for (int i = 0; i < 6; i++) begin
			hold = int'($urandom % (invaders_pkg::DEBOUNCE_CYCLES - 1)) + 1;
			press_buttons(i % 3 == 0, i % 3 == 1, i % 3 == 2, hold);
		end
		check_state();
		press_buttons(1'b0, 1'b1, 1'b0, 30); // Long hold gives one step.
		check_equal("ship_x", 32'(ship_x), 32'(invaders_pkg::SHIP_HOME + 1));
		check_state();
	endtask

	task automatic edge_limits();
		repeat (20) tap(1'b1, 1'b0, 1'b0);
		check_equal("ship_x", 32'(ship_x), 32'd0);
		repeat (25) tap(1'b0, 1'b1, 1'b0);
		check_equal("ship_x", 32'(ship_x), 32'(invaders_pkg::NUM_COLS - 1));
		tap(1'b1, 1'b1, 1'b0);
		check_equal("ship_x", 32'(ship_x), 32'(invaders_pkg::NUM_COLS - 2));
		check_state();
	endtask

	task automatic enable_freeze();
		enable = 1'b0;
		tap(1'b1, 1'b0, 1'b0);
		tap(1'b0, 1'b1, 1'b0);
		tap(1'b0, 1'b0, 1'b1);
		check_state();
		enable = 1'b1;
		tap(1'b0, 1'b0, 1'b1);
		check_state();
		enable = 1'b0;
		repeat (5 * invaders_pkg::STEP_CYCLES) @(negedge clk);
		// Frozen before its first row step.
		check_equal("missile_row", 32'(missile_row), 32'(invaders_pkg::MISSILE_START_ROW));
		check_state();
		enable = 1'b1;
		wait_missile_done();
		check_state();
	endtask

	task automatic hit_and_miss();
		int score_before;
		repeat (8) tap(1'b1, 1'b0, 1'b0);
		score_before = exp_score;
		tap(1'b0, 1'b0, 1'b1);
		check_equal("missile_col", 32'(missile_col), 32'(exp_ship));
		check_equal("missile_row", 32'(missile_row), 32'(invaders_pkg::MISSILE_START_ROW));
		check_state();
		tap(1'b0, 1'b0, 1'b1); // Second shot while in flight.
		// Two row steps since the first launch, so no relaunch.
		check_equal("missile_row", 32'(missile_row),
			32'(invaders_pkg::MISSILE_START_ROW - 2));
		check_state();
		wait_missile_done();
		check_equal("invaders_alive bit", 32'(invaders_alive[exp_ship]), 32'd0);
		check_equal("score", 32'(score), 32'(score_before + 1));
		check_state();
		tap(1'b0, 1'b0, 1'b1);
		check_state();
		wait_missile_done();
		check_equal("score", 32'(score), 32'(score_before + 1));
		check_state();
	endtask

	task automatic clear_wave();
		repeat (invaders_pkg::NUM_COLS) tap(1'b1, 1'b0, 1'b0);
		for (int c = 0; c < invaders_pkg::NUM_COLS; c++) begin
			if (exp_alive[c]) begin
				tap(1'b0, 1'b0, 1'b1);
				wait_missile_done();
				check_state();
			end
			if (c < invaders_pkg::NUM_COLS - 1) begin
				tap(1'b0, 1'b1, 1'b0);
			end
		end
		check_equal("invaders_alive", 32'(invaders_alive), 32'd0);
		check_equal("score", 32'(score), 32'(invaders_pkg::NUM_COLS));
		check_equal("wave_clear", 32'(wave_clear), 32'd1);
		check_state();
	endtask

	initial begin
		rand_val   = $urandom(32'hd5463606);
		errors     = 0;
		checks     = 0;
		reset      = 1'b0;
		enable     = 1'b1;
		btn_left   = 1'b0;
		btn_right  = 1'b0;
		btn_fire   = 1'b0;
		exp_ship   = invaders_pkg::SHIP_HOME;
		exp_alive  = '1;
		exp_score  = 0;
		exp_flying = 1'b0;
		exp_col    = 0;
		repeat (8) @(posedge clk);
		@(negedge clk);
		reset = 1'b1;
		@(negedge clk);
		reset_values();
		debounce_filter();
		edge_limits();
		enable_freeze();
		hit_and_miss();
		clear_wave();
		finish_run();
	end

endmodule

// ==== flist.f ====
invaders_pkg.sv
button_debounce.sv
ship_position.sv
missile_unit.sv
hit_tracker.sv
invaders_core.sv
tb_invaders_core.sv

// ==== Makefile ====
# Verilator simulation of the invaders player core.
TOP := tb_invaders_core

sim:
	verilator --binary --timing --assert -Wno-fatal -f flist.f --top-module $(TOP) -o sim_$(TOP)
	./obj_dir/sim_$(TOP) | tee sim.log
	grep -q "TESTBENCH PASSED" sim.log

clean:
	rm -rf obj_dir sim.log

.PHONY: sim clean
